// File: src/scrub_pkg.sv
// Shared types and constants for the DRAM scrubber block
// Widths, scrub region geometry, identity words and the scrubber states

package scrub_pkg;

  // --------------------------------------------------------------------------
  // Widths with a meaning
  // --------------------------------------------------------------------------
  localparam int NUM_CHAN = 4;

  typedef logic [31:0]         ctl_word_t;
  typedef logic [31:0]         stat_word_t;
  typedef logic [63:0]         ddr_addr_t;
  typedef logic [NUM_CHAN-1:0] chan_vec_t;
  typedef logic [2:0]          chan_sel_t;

  // --------------------------------------------------------------------------
  // Scrub region
  // --------------------------------------------------------------------------
  localparam int        SCRB_BURST_LEN_MINUS1 = 15;
  localparam int        SCRB_BEAT_BYTES       = 64;
  // 16 beats of 64 bytes, 0x400 per burst
  localparam ddr_addr_t SCRB_BURST_BYTES      = ddr_addr_t'((SCRB_BURST_LEN_MINUS1 + 1) *
                                                            SCRB_BEAT_BYTES);
  // Small 8 KiB region per channel
  localparam ddr_addr_t SCRB_MAX_ADDR         = 64'h1FFF;
  localparam ddr_addr_t SCRB_END_ADDR         = SCRB_MAX_ADDR + 64'd1;

  // Control word fields
  localparam int CTL_DBG_EN_BIT  = 31;
  localparam int CTL_DBG_SEL_LSB = 28;

  // --------------------------------------------------------------------------
  // Identity constants
  // --------------------------------------------------------------------------
  localparam logic [19:0] STAT_TAG   = 20'hA1111;
  localparam stat_word_t  CL_ID0     = 32'hF000_1D0F;
  localparam stat_word_t  CL_ID1     = 32'h1D51_FEDD;
  localparam stat_word_t  CL_VERSION = 32'hEEEE_EE00;

  // Scrubber FSM, 3 bits so a state fits a status nibble with a spare bit
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    INIT  = 3'd1,
    SCRUB = 3'd2,
    DONE  = 3'd3
  } scrb_state_t;

endpackage

// File: src/scrub_if.sv
// Per-channel scrubber bundle
// Enable and ready come from the decoder, state, address and done from the engine

interface scrub_if import scrub_pkg::*; ();

  logic        enable;
  logic        ready;
  scrb_state_t state;
  ddr_addr_t   addr;
  logic        done;

  // Control side, drives the per-channel levels
  modport ctl (output enable, output ready);

  // Scrub engine
  modport engine (input enable, input ready, output state, output addr, output done);

  // Status readback sees everything
  modport observer (input enable, input ready, input state, input addr, input done);

endinterface

// File: src/ctl_decode.sv
// Control decoder for the scrubber block
// Registers the control word and DDR-ready vector, fans out per-channel
// enables and ready, debug fields and the FLR response

module ctl_decode import scrub_pkg::*;
(
  input  logic       clk,
  input  logic       sync_rst_n,
  input  ctl_word_t  ctl0,
  input  chan_vec_t  ddr_is_ready,
  input  logic       flr_assert,
  scrub_if.ctl       chan [NUM_CHAN],
  output logic       dbg_en,
  output chan_sel_t  dbg_sel,
  output logic       flr_done
);

  ctl_word_t ctl_q;
  chan_vec_t rdy_q;
  logic      flr_assert_q;

  // --------------------------------------------------------------------------
  // Input registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      ctl_q <= '0;
      rdy_q <= '0;
    end
    else
    begin
      ctl_q <= ctl0;
      rdy_q <= ddr_is_ready;
    end
  end

  // Control bit i enables scrubber i
  for (genvar i = 0; i < NUM_CHAN; i++)
  begin : g_chan
    assign chan[i].enable = ctl_q[i];
    assign chan[i].ready  = rdy_q[i];
  end

  assign dbg_en  = ctl_q[CTL_DBG_EN_BIT];
  assign dbg_sel = ctl_q[CTL_DBG_SEL_LSB +: $bits(chan_sel_t)];

  // --------------------------------------------------------------------------
  // FLR response
  // --------------------------------------------------------------------------
  // Done follows the delayed assert, toggling while assert is held
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      flr_assert_q <= 1'b0;
      flr_done     <= 1'b0;
    end
    else
    begin
      flr_assert_q <= flr_assert;
      flr_done     <= flr_assert_q && !flr_done;
    end
  end

endmodule

// File: src/ddr_scrubber.sv
// Scrub engine for one DRAM channel
// Walks the scrub region in fixed bursts, one burst per accepted write

module ddr_scrubber import scrub_pkg::*;
(
  input  logic   clk,
  input  logic   sync_rst_n,
  scrub_if.engine chan,
  input  logic   wr_ready,
  output logic   wr_valid
);

  scrb_state_t state_q;
  ddr_addr_t   addr_q;
  ddr_addr_t   addr_nxt;
  logic        burst_acc;

  // Address of the following burst
  assign addr_nxt = addr_q + SCRB_BURST_BYTES;

  // Offer a burst only while still enabled so none is lost on disable
  assign wr_valid  = (state_q == SCRUB) && chan.enable;
  assign burst_acc = wr_valid && wr_ready;

  // --------------------------------------------------------------------------
  // Scrub FSM and address counter
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      state_q <= IDLE;
      addr_q  <= '0;
    end
    else if (!chan.enable)
    begin
      // Disable aborts from any state
      state_q <= IDLE;
      addr_q  <= '0;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          state_q <= INIT;
          addr_q  <= '0;
        end
        INIT:
        begin
          // Wait for the channel's memory to come up
          if (chan.ready)
            state_q <= SCRUB;
        end
        SCRUB:
        begin
          if (burst_acc)
          begin
            addr_q <= addr_nxt;
            if (addr_nxt == SCRB_END_ADDR)
              state_q <= DONE;
          end
        end
        DONE:
        begin
          // Hold end address until disabled
          state_q <= DONE;
        end
        default:
        begin
          state_q <= IDLE;
          addr_q  <= '0;
        end
      endcase
    end
  end

  assign chan.state = state_q;
  assign chan.addr  = addr_q;
  assign chan.done  = (state_q == DONE);

endmodule

// File: src/status_result.sv
// Status formatter for the scrubber block
// Builds the registered status and ID words from scrubber and ready information

module status_result import scrub_pkg::*;
(
  input  logic       clk,
  input  logic       sync_rst_n,
  scrub_if.observer  chan [NUM_CHAN],
  input  logic       dbg_en,
  input  chan_sel_t  dbg_sel,
  output stat_word_t status0,
  output stat_word_t status1,
  output stat_word_t id0,
  output stat_word_t id1
);

  chan_vec_t             done_vec;
  chan_vec_t             rdy_vec;
  scrb_state_t           state_arr [NUM_CHAN];
  ddr_addr_t             addr_arr  [NUM_CHAN];
  logic [4*NUM_CHAN-1:0] dbg_states;
  logic [1:0]            sel_idx;
  ddr_addr_t             sel_addr;
  stat_word_t            status0_nxt;

  // --------------------------------------------------------------------------
  // Gather per-channel information
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < NUM_CHAN; i++)
  begin : g_gather
    assign done_vec[i]  = chan[i].done;
    assign rdy_vec[i]   = chan[i].ready;
    assign state_arr[i] = chan[i].state;
    assign addr_arr[i]  = chan[i].addr;
    // One nibble per channel, spare top bit reads zero
    assign dbg_states[4*i +: 4] = {1'b0, state_arr[i]};
  end

  // Select values 4 to 7 fall back to channel 0
  assign sel_idx  = dbg_sel[2] ? 2'd0 : dbg_sel[1:0];
  assign sel_addr = addr_arr[sel_idx];

  assign status0_nxt = dbg_en ? {dbg_states, 4'h0, 4'hF, done_vec, rdy_vec}
                              : {STAT_TAG, 4'hF, done_vec, rdy_vec};

  // --------------------------------------------------------------------------
  // Output registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      status0 <= '0;
      status1 <= CL_VERSION;
      id0     <= '0;
      id1     <= '0;
    end
    else
    begin
      status0 <= status0_nxt;
      status1 <= CL_VERSION;
      // Debug mode swaps the identity for the selected scrub address
      id0     <= dbg_en ? sel_addr[31:0]  : CL_ID0;
      id1     <= dbg_en ? sel_addr[63:32] : CL_ID1;
    end
  end

endmodule

// File: src/dram_scrub_top.sv
// DRAM scrubber top level
// Control decode, four channel scrubbers and the status formatter

module dram_scrub_top import scrub_pkg::*;
(
  input  logic       clk,
  input  logic       sync_rst_n,
  input  ctl_word_t  ctl0,
  input  chan_vec_t  ddr_is_ready,
  input  chan_vec_t  scrub_wr_ready,
  input  logic       flr_assert,
  output stat_word_t status0,
  output stat_word_t status1,
  output stat_word_t id0,
  output stat_word_t id1,
  output chan_vec_t  scrub_wr_valid,
  output logic       flr_done
);

  logic      dbg_en;
  chan_sel_t dbg_sel;

  // One bundle per DRAM channel
  scrub_if chan_if [NUM_CHAN] ();

  // --------------------------------------------------------------------------
  // Decode
  // --------------------------------------------------------------------------
  ctl_decode u_ctl_decode (
    .clk          (clk),
    .sync_rst_n   (sync_rst_n),
    .ctl0         (ctl0),
    .ddr_is_ready (ddr_is_ready),
    .flr_assert   (flr_assert),
    .chan         (chan_if),
    .dbg_en       (dbg_en),
    .dbg_sel      (dbg_sel),
    .flr_done     (flr_done)
  );

  // --------------------------------------------------------------------------
  // Scrubber array
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < NUM_CHAN; i++)
  begin : g_scrub
    ddr_scrubber u_ddr_scrubber (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .chan       (chan_if[i]),
      .wr_ready   (scrub_wr_ready[i]),
      .wr_valid   (scrub_wr_valid[i])
    );
  end

  // --------------------------------------------------------------------------
  // Status
  // --------------------------------------------------------------------------
  status_result u_status_result (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .chan       (chan_if),
    .dbg_en     (dbg_en),
    .dbg_sel    (dbg_sel),
    .status0    (status0),
    .status1    (status1),
    .id0        (id0),
    .id1        (id1)
  );

endmodule

// File: verification/scrub_props.sv
// Scrubber FSM checks, bound to every ddr_scrubber instance

module scrub_props import scrub_pkg::*;
(
  input logic        clk,
  input logic        sync_rst_n,
  input logic        enable,
  input scrb_state_t state,
  input ddr_addr_t   addr,
  input logic        done,
  input logic        wr_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  // Address stays inside the scrub region
  a_addr_in_region: assert property (@(posedge clk) disable iff (!sync_rst_n)
    addr <= SCRB_END_ADDR)
    else $error("scrub address 0x%0h is past the region end", addr);

  // Done only in DONE, once the whole region is walked
  a_done_in_done: assert property (@(posedge clk) disable iff (!sync_rst_n)
    done |-> ((state == DONE) && (addr == SCRB_END_ADDR)))
    else $error("done flag high outside the DONE state or before the region end");

  // No start without enable
  a_idle_needs_enable: assert property (@(posedge clk) disable iff (!sync_rst_n)
    ((state == IDLE) && !enable) |=> (state == IDLE))
    else $error("scrubber left IDLE while disabled");

  // Bursts only in SCRUB and never past the region
  a_valid_in_scrub: assert property (@(posedge clk) disable iff (!sync_rst_n)
    wr_valid |-> ((state == SCRUB) && (addr < SCRB_END_ADDR)))
    else $error("write valid high outside the SCRUB state or past the region end");

endmodule

// File: verification/tb_dram_scrub.sv
// Directed testbench for the DRAM scrubber top level
// Drives control, DDR-ready, write-ready and FLR inputs, checks status, ID and bursts

module tb_dram_scrub;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_PERIOD    = 40;
  localparam int          RESET_CYCLES  = 16;
  localparam int          SCRUB_TIMEOUT = 2000;
  localparam int          WAIT_TIMEOUT  = 100;
  // Register map values of the block
  localparam logic [19:0] EXP_STAT_TAG  = 20'hA1111;
  localparam logic [31:0] EXP_ID0       = 32'hF000_1D0F;
  localparam logic [31:0] EXP_ID1       = 32'h1D51_FEDD;
  localparam logic [31:0] EXP_VERSION   = 32'hEEEE_EE00;
  localparam logic [31:0] EXP_END_ADDR  = 32'h0000_2000;
  // 8 KiB region walked in 1 KiB bursts
  localparam int          EXP_BURSTS    = 8;

  logic        clk = 1'b0;
  logic        sync_rst_n;
  logic [31:0] ctl0;
  logic [3:0]  ddr_is_ready;
  logic [3:0]  scrub_wr_ready;
  logic        flr_assert;
  logic [31:0] status0;
  logic [31:0] status1;
  logic [31:0] id0;
  logic [31:0] id1;
  logic [3:0]  scrub_wr_valid;
  logic        flr_done;

  always #(CLK_PERIOD / 2) clk = ~clk;

  dram_scrub_top dut (
    .clk            (clk),
    .sync_rst_n     (sync_rst_n),
    .ctl0           (ctl0),
    .ddr_is_ready   (ddr_is_ready),
    .scrub_wr_ready (scrub_wr_ready),
    .flr_assert     (flr_assert),
    .status0        (status0),
    .status1        (status1),
    .id0            (id0),
    .id1            (id1),
    .scrub_wr_valid (scrub_wr_valid),
    .flr_done       (flr_done)
  );

  // FSM checks on every channel
  bind ddr_scrubber scrub_props u_scrub_props (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .enable     (chan.enable),
    .state      (state_q),
    .addr       (addr_q),
    .done       (chan.done),
    .wr_valid   (wr_valid)
  );

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped after a failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
      stop_with_failure($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h",
                                  name, got, exp));
  endtask

  // Debug enable in bit 31, select in 30:28, channel enables in 3:0
  function automatic logic [31:0] ctl_word(input logic dbg, input logic [2:0] sel,
                                           input logic [3:0] en);
    return {dbg, sel, 24'h0, en};
  endfunction

  // Fixed register latency, then sample mid-cycle
  task automatic skip_cycles(input int n);
    repeat (n) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic wait_done_bits(input logic [3:0] mask, input int max_cycles);
    int cycles;
    cycles = 0;
    while ((status0[7:4] & mask) != mask)
    begin
      if (cycles >= max_cycles)
        stop_with_failure("timed out waiting for the scrubber done flags");
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic wait_valid_bit(input int ch, input int max_cycles);
    int cycles;
    cycles = 0;
    while (!scrub_wr_valid[ch])
    begin
      if (cycles >= max_cycles)
        stop_with_failure($sformatf("timed out waiting for a burst on channel %0d", ch));
      @(negedge clk);
      cycles++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  task automatic test_reset_status();
    @(posedge clk);
    ddr_is_ready <= 4'h6;
    skip_cycles(2);
    check_value("status0", status0, {EXP_STAT_TAG, 4'hF, 4'h0, 4'h6});
    check_value("status1", status1, EXP_VERSION);
    check_value("id0", id0, EXP_ID0);
    check_value("id1", id1, EXP_ID1);
  endtask

  task automatic test_scrub_all();
    int bursts [4];
    int cycles;
    foreach (bursts[ch])
      bursts[ch] = 0;
    cycles = 0;
    @(posedge clk);
    ddr_is_ready <= 4'hF;
    ctl0         <= ctl_word(1'b0, 3'd0, 4'hF);
    @(negedge clk);
    while (status0[7:4] != 4'hF)
    begin
      if (cycles >= SCRUB_TIMEOUT)
        stop_with_failure("scrub of all channels did not finish in time");
      @(posedge clk);
      scrub_wr_ready <= 4'($urandom);
      // Valid and ready seen here are the pair of the next edge
      @(negedge clk);
      for (int ch = 0; ch < 4; ch++)
      begin
        if (scrub_wr_valid[ch] && scrub_wr_ready[ch])
          bursts[ch]++;
      end
      cycles++;
    end
    foreach (bursts[ch])
      check_value($sformatf("bursts[%0d]", ch), 32'(bursts[ch]), 32'(EXP_BURSTS));
    check_value("status0", status0, {EXP_STAT_TAG, 4'hF, 4'hF, 4'hF});
  endtask

  task automatic test_debug_readback();
    for (int sel = 0; sel < 4; sel++)
    begin
      @(posedge clk);
      ctl0 <= ctl_word(1'b1, 3'(sel), 4'hF);
      skip_cycles(2);
      check_value($sformatf("id0 sel %0d", sel), id0, EXP_END_ADDR);
      check_value($sformatf("id1 sel %0d", sel), id1, 32'h0);
    end
    // Out-of-range select reads channel 0
    @(posedge clk);
    ctl0 <= ctl_word(1'b1, 3'd5, 4'hF);
    skip_cycles(2);
    check_value("id0 sel 5", id0, EXP_END_ADDR);
    check_value("id1 sel 5", id1, 32'h0);
    check_value("status0", status0, 32'h3333_0FFF);
  endtask

  task automatic test_enable_drop();
    @(posedge clk);
    ctl0 <= ctl_word(1'b1, 3'd2, 4'b1011);
    skip_cycles(3);
    check_value("status0", status0, 32'h3033_0FBF);
    check_value("id0", id0, 32'h0);
    check_value("id1", id1, 32'h0);
  endtask

  task automatic test_ready_gating();
    @(posedge clk);
    ctl0           <= ctl_word(1'b1, 3'd0, 4'h0);
    ddr_is_ready   <= 4'hE;
    scrub_wr_ready <= 4'h0;
    skip_cycles(3);
    @(posedge clk);
    ctl0 <= ctl_word(1'b1, 3'd0, 4'h1);
    skip_cycles(3);
    check_value("status0 state ch0", 32'(status0[19:16]), 32'h1);
    // Memory not ready, no burst may start
    for (int i = 0; i < 10; i++)
    begin
      @(negedge clk);
      check_value("scrub_wr_valid", 32'(scrub_wr_valid), 32'h0);
    end
    @(posedge clk);
    ddr_is_ready <= 4'hF;
    @(negedge clk);
    wait_valid_bit(0, WAIT_TIMEOUT);
    // Back-pressure holds the address
    for (int i = 0; i < 10; i++)
    begin
      @(negedge clk);
      check_value("id0 under back-pressure", id0, 32'h0);
      check_value("status0 state ch0", 32'(status0[19:16]), 32'h2);
    end
    @(posedge clk);
    scrub_wr_ready <= 4'h1;
    @(negedge clk);
    wait_done_bits(4'h1, WAIT_TIMEOUT);
    check_value("id0", id0, EXP_END_ADDR);
    check_value("status0", status0, 32'h0003_0F1F);
  endtask

  task automatic test_flr_response();
    logic [4:0] exp_done;
    // Bit i is flr_done after edge i, edge 0 drives the pulse
    exp_done = 5'b00100;
    @(negedge clk);
    check_value("flr_done idle", 32'(flr_done), 32'h0);
    @(posedge clk);
    flr_assert <= 1'b1;
    for (int i = 0; i < 5; i++)
    begin
      if (i > 0)
        @(posedge clk);
      if (i == 1)
        flr_assert <= 1'b0;
      @(negedge clk);
      check_value($sformatf("flr_done edge %0d", i), 32'(flr_done), 32'(exp_done[i]));
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial
  begin
    void'($urandom(32'hee87));
    sync_rst_n     = 1'b0;
    ctl0           = 32'h0;
    ddr_is_ready   = 4'h0;
    scrub_wr_ready = 4'h0;
    flr_assert     = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    sync_rst_n <= 1'b1;

    test_reset_status();
    test_scrub_all();
    test_debug_readback();
    test_enable_drop();
    test_ready_gating();
    test_flr_response();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: filelist.f
src/scrub_pkg.sv
src/scrub_if.sv
src/ctl_decode.sv
src/ddr_scrubber.sv
src/status_result.sv
src/dram_scrub_top.sv
verification/scrub_props.sv
verification/tb_dram_scrub.sv

// File: Makefile
# Verilator build and run for the DRAM scrubber testbench

VERILATOR ?= verilator
TOP       ?= tb_dram_scrub
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard src/*.sv verification/*.sv)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation binary is the pass or fail result
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
